//--- uce_settings.svh
// fixed widths and counts; block width must be a multiple of 64 and sets a power of two
`ifndef UCE_SETTINGS_SVH
`define UCE_SETTINGS_SVH

`define UCE_PADDR_WIDTH 32
`define UCE_BLOCK_WIDTH 128
`define UCE_DWORD_WIDTH 64
`define UCE_SETS 8
`define UCE_ASSOC 2
`define UCE_MAX_CREDITS 4

// derived widths
`define UCE_INDEX_WIDTH ($clog2(`UCE_SETS))
`define UCE_WAY_WIDTH ($clog2(`UCE_ASSOC))
`define UCE_BLOCK_OFFSET_WIDTH ($clog2(`UCE_BLOCK_WIDTH / 8))

// tag is whatever is left above index and block offset
`define UCE_CTAG_WIDTH \
  (`UCE_PADDR_WIDTH - `UCE_INDEX_WIDTH - `UCE_BLOCK_OFFSET_WIDTH)

`endif

//--- uce_pkg.sv
// shared types for the engine; all widths come from uce_settings.svh and are fixed per build
`include "uce_settings.svh"

package uce_pkg;

  typedef logic [`UCE_PADDR_WIDTH-1:0]        paddr_t;
  typedef logic [`UCE_INDEX_WIDTH-1:0]        index_t;
  typedef logic [`UCE_WAY_WIDTH-1:0]          way_t;
  typedef logic [`UCE_CTAG_WIDTH-1:0]         ctag_t;
  typedef logic [`UCE_BLOCK_WIDTH-1:0]        block_t;
  typedef logic [`UCE_DWORD_WIDTH-1:0]        dword_t;

  // one extra bit so the count can reach the maximum itself
  typedef logic [$clog2(`UCE_MAX_CREDITS+1)-1:0] credit_cnt_t;

  // request kinds coming from the cache controller
  typedef enum logic [1:0] {
    e_miss_load
    , e_miss_store
    , e_uc_load
    , e_uc_store
  } req_type_e;

  // memory network message kinds, used in both directions
  typedef enum logic [1:0] {
    e_mem_rd
    , e_mem_uc_rd
    , e_mem_uc_wr
  } mem_msg_e;

  typedef enum logic [2:0] {
    e_reset
    , e_init
    , e_ready
    , e_send_critical
    , e_read_wait
    , e_uc_read_wait
  } uce_state_e;

endpackage

//--- uce_req_reg.sv
// holds one cache request; payload is only meaningful while req_v_o is high
`timescale 1ns/1ns

module uce_req_reg
  (input                         clk_i
   , input                       reset_i

   , input                       cache_req_v_i
   , input                       cache_req_ready_and_i
   , input uce_pkg::req_type_e   cache_req_type_i
   , input uce_pkg::paddr_t      cache_req_addr_i
   , input [1:0]                 cache_req_size_i
   , input uce_pkg::dword_t      cache_req_data_i
   , input uce_pkg::way_t        cache_req_way_i

   , input                       done_i

   , output logic                req_v_o
   , output uce_pkg::req_type_e  req_type_o
   , output uce_pkg::paddr_t     req_addr_o
   , output logic [1:0]          req_size_o
   , output uce_pkg::dword_t     req_data_o
   , output uce_pkg::way_t       req_way_o
   );

  logic xfer;

  assign xfer = cache_req_v_i & cache_req_ready_and_i;

  // a new transfer wins over done so back-to-back stores stay valid
  always_ff @(posedge clk_i)
    if (reset_i)
      req_v_o <= 1'b0;
    else if (xfer)
      req_v_o <= 1'b1;
    else if (done_i)
      req_v_o <= 1'b0;

  always_ff @(posedge clk_i)
    if (xfer)
      begin
        req_type_o <= cache_req_type_i;
        req_addr_o <= cache_req_addr_i;
        req_size_o <= cache_req_size_i;
        req_data_o <= cache_req_data_i;
        req_way_o  <= cache_req_way_i;
      end

  // the fsm must only finish a request that was actually captured
  a_done_has_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    done_i |-> req_v_o
  ) else $error("done without a held request");

endmodule

//--- uce_credit_counter.sv
// counts outstanding memory commands up to UCE_MAX_CREDITS; every forward message gets one reply
`timescale 1ns/1ns
`include "uce_settings.svh"

module uce_credit_counter
  (input          clk_i
   , input        reset_i

   , input        fwd_fire_i
   , input        rev_fire_i

   , output logic credit_avail_o
   , output logic count_zero_o
   , output logic count_full_o
   );

  import uce_pkg::*;

  localparam credit_cnt_t max_credits_lp = credit_cnt_t'(`UCE_MAX_CREDITS);

  credit_cnt_t count_r;

  // simultaneous send and return cancel out
  always_ff @(posedge clk_i)
    if (reset_i)
      count_r <= '0;
    else if (fwd_fire_i & ~rev_fire_i)
      count_r <= count_r + 1'b1;
    else if (rev_fire_i & ~fwd_fire_i)
      count_r <= count_r - 1'b1;

  assign count_zero_o   = (count_r == '0);
  assign count_full_o   = (count_r == max_credits_lp);
  assign credit_avail_o = (count_r < max_credits_lp);

  // memory must not return more than was sent, and the fsm must respect credit_avail
  a_count_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (fwd_fire_i != rev_fire_i) |-> (fwd_fire_i ? !count_full_o : !count_zero_o)
  ) else $error("credit count out of range");

endmodule

//--- uce_fsm.sv
// control fsm; blocking, so only one miss or uncached load is in flight, while stores are posted
`timescale 1ns/1ns
`include "uce_settings.svh"

module uce_fsm
  (input                          clk_i
   , input                        reset_i

   , input                        req_v_i
   , input uce_pkg::req_type_e    req_type_i
   , input uce_pkg::paddr_t       req_addr_i
   , input [1:0]                  req_size_i
   , input uce_pkg::dword_t       req_data_i
   , input uce_pkg::way_t         req_way_i

   , input                        credit_avail_i

   , input                        tag_mem_yumi_i
   , input                        data_mem_yumi_i
   , input                        uc_data_yumi_i
   , input                        mem_fwd_ready_and_i

   , input                        mem_rev_v_i
   , input uce_pkg::mem_msg_e     mem_rev_type_i
   , input uce_pkg::paddr_t       mem_rev_addr_i
   , input uce_pkg::block_t       mem_rev_data_i
   , input uce_pkg::way_t         mem_rev_way_i

   , input                        cache_req_v_i
   , input uce_pkg::req_type_e    cache_req_type_i

   , output logic                 cache_req_ready_and_o
   , output logic                 cache_req_busy_o
   , output logic                 cache_req_complete_o
   , output logic                 done_o

   , output logic                 tag_mem_v_o
   , output logic                 tag_mem_clear_o
   , output uce_pkg::index_t      tag_mem_index_o
   , output uce_pkg::way_t        tag_mem_way_o
   , output uce_pkg::ctag_t       tag_mem_tag_o

   , output logic                 data_mem_v_o
   , output uce_pkg::index_t      data_mem_index_o
   , output uce_pkg::way_t        data_mem_way_o
   , output uce_pkg::block_t      data_mem_data_o

   , output logic                 uc_data_v_o
   , output uce_pkg::dword_t      uc_data_o

   , output logic                 mem_fwd_v_o
   , output uce_pkg::mem_msg_e    mem_fwd_type_o
   , output uce_pkg::paddr_t      mem_fwd_addr_o
   , output logic [1:0]           mem_fwd_size_o
   , output uce_pkg::block_t      mem_fwd_data_o
   , output uce_pkg::way_t        mem_fwd_way_o

   , output logic                 mem_rev_ready_and_o
   );

  import uce_pkg::*;

  localparam int block_offset_lp = `UCE_BLOCK_OFFSET_WIDTH;
  localparam int index_width_lp  = `UCE_INDEX_WIDTH;
  localparam int dwords_lp       = `UCE_BLOCK_WIDTH / `UCE_DWORD_WIDTH;

  uce_state_e state_r, state_n;
  index_t index_r;
  logic index_up, index_last;
  logic store_ack_v, load_resp_v, load_resp_yumi;

  // store acks are drained here in every state
  assign store_ack_v = mem_rev_v_i & (mem_rev_type_i == e_mem_uc_wr);
  assign load_resp_v = mem_rev_v_i & (mem_rev_type_i != e_mem_uc_wr);
  assign mem_rev_ready_and_o = store_ack_v | load_resp_yumi;

  assign index_last = (index_r == index_t'(`UCE_SETS - 1));
  assign cache_req_busy_o = (state_r == e_reset) || (state_r == e_init);
  assign cache_req_complete_o = done_o & (req_type_i != e_uc_store);

  // fill fields come straight from the response, not the held request
  assign tag_mem_tag_o    = mem_rev_addr_i[block_offset_lp+index_width_lp+:`UCE_CTAG_WIDTH];
  assign data_mem_index_o = mem_rev_addr_i[block_offset_lp+:index_width_lp];
  assign data_mem_way_o   = mem_rev_way_i;
  assign data_mem_data_o  = mem_rev_data_i;
  assign uc_data_o        = mem_rev_data_i[`UCE_DWORD_WIDTH-1:0];

  always_comb
    begin
      state_n = state_r;
      cache_req_ready_and_o = 1'b0;
      done_o = 1'b0;
      index_up = 1'b0;
      load_resp_yumi = 1'b0;
      tag_mem_v_o = 1'b0;
      tag_mem_clear_o = 1'b0;
      tag_mem_index_o = data_mem_index_o;
      tag_mem_way_o = mem_rev_way_i;
      data_mem_v_o = 1'b0;
      uc_data_v_o = 1'b0;
      mem_fwd_v_o = 1'b0;
      mem_fwd_type_o = e_mem_rd;
      mem_fwd_addr_o = req_addr_i;
      mem_fwd_size_o = req_size_i;
      mem_fwd_data_o = '0;
      mem_fwd_way_o = req_way_i;

      unique case (state_r)
        e_reset:
          state_n = e_init;
        e_init:
          begin
            tag_mem_v_o = 1'b1;
            tag_mem_clear_o = 1'b1;
            tag_mem_index_o = index_r;
            tag_mem_way_o = '0;
            index_up = tag_mem_yumi_i;
            state_n = (index_up & index_last) ? e_ready : e_init;
          end
        e_ready:
          begin
            // only a posted store can be held here
            if (req_v_i && (req_type_i == e_uc_store))
              begin
                mem_fwd_v_o = credit_avail_i;
                mem_fwd_type_o = e_mem_uc_wr;
                mem_fwd_data_o = {dwords_lp{req_data_i}};
                done_o = mem_fwd_v_o & mem_fwd_ready_and_i;
              end
            cache_req_ready_and_o = ~req_v_i | done_o;
            if (cache_req_ready_and_o & cache_req_v_i)
              state_n = (cache_req_type_i == e_uc_store) ? e_ready : e_send_critical;
          end
        e_send_critical:
          begin
            mem_fwd_v_o = credit_avail_i;
            if (req_type_i == e_uc_load)
              mem_fwd_type_o = e_mem_uc_rd;
            else
              begin
                // whole block read; size has no meaning for rd
                mem_fwd_addr_o = {req_addr_i[`UCE_PADDR_WIDTH-1:block_offset_lp],
                                  block_offset_lp'(0)};
                mem_fwd_size_o = '1;
              end
            if (mem_fwd_v_o & mem_fwd_ready_and_i)
              state_n = (req_type_i == e_uc_load) ? e_uc_read_wait : e_read_wait;
          end
        e_read_wait:
          begin
            tag_mem_v_o = load_resp_v;
            data_mem_v_o = load_resp_v;
            load_resp_yumi = load_resp_v & tag_mem_yumi_i & data_mem_yumi_i;
            done_o = load_resp_yumi;
            state_n = done_o ? e_ready : e_read_wait;
          end
        e_uc_read_wait:
          begin
            uc_data_v_o = load_resp_v;
            load_resp_yumi = uc_data_v_o & uc_data_yumi_i;
            done_o = load_resp_yumi;
            state_n = done_o ? e_ready : e_uc_read_wait;
          end
        default:
          state_n = e_reset;
      endcase
    end

  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        state_r <= e_reset;
        index_r <= '0;
      end
    else
      begin
        state_r <= state_n;
        if (index_up)
          index_r <= index_r + 1'b1;
      end

endmodule

//--- uce_top.sv
// uncached engine top; one blocking miss or uncached load at a time, stores posted under credits
`timescale 1ns/1ns

module uce_top
  (input                          clk_i
   , input                        reset_i

   , input                        cache_req_v_i
   , input uce_pkg::req_type_e    cache_req_type_i
   , input uce_pkg::paddr_t       cache_req_addr_i
   , input [1:0]                  cache_req_size_i
   , input uce_pkg::dword_t       cache_req_data_i
   , input uce_pkg::way_t         cache_req_way_i
   , output logic                 cache_req_ready_and_o
   , output logic                 cache_req_busy_o
   , output logic                 cache_req_complete_o
   , output logic                 cache_req_credits_full_o
   , output logic                 cache_req_credits_empty_o

   , output logic                 tag_mem_v_o
   , output logic                 tag_mem_clear_o
   , output uce_pkg::index_t      tag_mem_index_o
   , output uce_pkg::way_t        tag_mem_way_o
   , output uce_pkg::ctag_t       tag_mem_tag_o
   , input                        tag_mem_yumi_i

   , output logic                 data_mem_v_o
   , output uce_pkg::index_t      data_mem_index_o
   , output uce_pkg::way_t        data_mem_way_o
   , output uce_pkg::block_t      data_mem_data_o
   , input                        data_mem_yumi_i

   , output logic                 uc_data_v_o
   , output uce_pkg::dword_t      uc_data_o
   , input                        uc_data_yumi_i

   , output logic                 mem_fwd_v_o
   , output uce_pkg::mem_msg_e    mem_fwd_type_o
   , output uce_pkg::paddr_t      mem_fwd_addr_o
   , output logic [1:0]           mem_fwd_size_o
   , output uce_pkg::block_t      mem_fwd_data_o
   , output uce_pkg::way_t        mem_fwd_way_o
   , input                        mem_fwd_ready_and_i

   , input                        mem_rev_v_i
   , input uce_pkg::mem_msg_e     mem_rev_type_i
   , input uce_pkg::paddr_t       mem_rev_addr_i
   , input uce_pkg::block_t       mem_rev_data_i
   , input uce_pkg::way_t         mem_rev_way_i
   , output logic                 mem_rev_ready_and_o
   );

  import uce_pkg::*;

  logic req_v, done, credit_avail, count_zero, count_full;
  req_type_e req_type;
  paddr_t req_addr;
  logic [1:0] req_size;
  dword_t req_data;
  way_t req_way;

  // a held request counts as pending work for the cache's fence logic
  assign cache_req_credits_full_o  = req_v & count_full;
  assign cache_req_credits_empty_o = ~req_v & count_zero;

  uce_req_reg u_req_reg
    (.clk_i(clk_i), .reset_i(reset_i)
     , .cache_req_v_i(cache_req_v_i), .cache_req_ready_and_i(cache_req_ready_and_o)
     , .cache_req_type_i(cache_req_type_i), .cache_req_addr_i(cache_req_addr_i)
     , .cache_req_size_i(cache_req_size_i), .cache_req_data_i(cache_req_data_i)
     , .cache_req_way_i(cache_req_way_i), .done_i(done)
     , .req_v_o(req_v), .req_type_o(req_type), .req_addr_o(req_addr)
     , .req_size_o(req_size), .req_data_o(req_data), .req_way_o(req_way)
     );

  uce_credit_counter u_credit_counter
    (.clk_i(clk_i), .reset_i(reset_i)
     , .fwd_fire_i(mem_fwd_v_o & mem_fwd_ready_and_i)
     , .rev_fire_i(mem_rev_v_i & mem_rev_ready_and_o)
     , .credit_avail_o(credit_avail), .count_zero_o(count_zero), .count_full_o(count_full)
     );

  uce_fsm u_fsm
    (.clk_i(clk_i), .reset_i(reset_i)
     , .req_v_i(req_v), .req_type_i(req_type), .req_addr_i(req_addr)
     , .req_size_i(req_size), .req_data_i(req_data), .req_way_i(req_way)
     , .credit_avail_i(credit_avail), .tag_mem_yumi_i(tag_mem_yumi_i)
     , .data_mem_yumi_i(data_mem_yumi_i), .uc_data_yumi_i(uc_data_yumi_i)
     , .mem_fwd_ready_and_i(mem_fwd_ready_and_i), .mem_rev_v_i(mem_rev_v_i)
     , .mem_rev_type_i(mem_rev_type_i), .mem_rev_addr_i(mem_rev_addr_i)
     , .mem_rev_data_i(mem_rev_data_i), .mem_rev_way_i(mem_rev_way_i)
     , .cache_req_v_i(cache_req_v_i), .cache_req_type_i(cache_req_type_i)
     , .cache_req_ready_and_o(cache_req_ready_and_o), .cache_req_busy_o(cache_req_busy_o)
     , .cache_req_complete_o(cache_req_complete_o), .done_o(done)
     , .tag_mem_v_o(tag_mem_v_o), .tag_mem_clear_o(tag_mem_clear_o)
     , .tag_mem_index_o(tag_mem_index_o), .tag_mem_way_o(tag_mem_way_o)
     , .tag_mem_tag_o(tag_mem_tag_o), .data_mem_v_o(data_mem_v_o)
     , .data_mem_index_o(data_mem_index_o), .data_mem_way_o(data_mem_way_o)
     , .data_mem_data_o(data_mem_data_o), .uc_data_v_o(uc_data_v_o), .uc_data_o(uc_data_o)
     , .mem_fwd_v_o(mem_fwd_v_o), .mem_fwd_type_o(mem_fwd_type_o)
     , .mem_fwd_addr_o(mem_fwd_addr_o), .mem_fwd_size_o(mem_fwd_size_o)
     , .mem_fwd_data_o(mem_fwd_data_o), .mem_fwd_way_o(mem_fwd_way_o)
     , .mem_rev_ready_and_o(mem_rev_ready_and_o)
     );

endmodule

//--- tb_uce.sv
// directed testbench; array stubs always consume, memory answers each command 3 cycles later
`timescale 1ns/1ns
`include "uce_settings.svh"

module tb_uce;

  import uce_pkg::*;

  // init takes about 10 cycles and each test well under 100
  localparam int timeout_cycles_lp = 2000;
  localparam int resp_delay_lp = 3;
  localparam int block_bytes_lp = `UCE_BLOCK_WIDTH / 8;

  logic clk_i, reset_i;
  logic cache_req_v_i, cache_req_ready_and_o, cache_req_busy_o, cache_req_complete_o;
  logic cache_req_credits_full_o, cache_req_credits_empty_o;
  req_type_e cache_req_type_i;
  paddr_t cache_req_addr_i;
  logic [1:0] cache_req_size_i;
  dword_t cache_req_data_i;
  way_t cache_req_way_i;
  logic tag_mem_v_o, tag_mem_clear_o, tag_mem_yumi_i;
  index_t tag_mem_index_o;
  way_t tag_mem_way_o;
  ctag_t tag_mem_tag_o;
  logic data_mem_v_o, data_mem_yumi_i;
  index_t data_mem_index_o;
  way_t data_mem_way_o;
  block_t data_mem_data_o;
  logic uc_data_v_o, uc_data_yumi_i;
  dword_t uc_data_o;
  logic mem_fwd_v_o, mem_fwd_ready_and_i;
  mem_msg_e mem_fwd_type_o;
  paddr_t mem_fwd_addr_o;
  logic [1:0] mem_fwd_size_o;
  block_t mem_fwd_data_o;
  way_t mem_fwd_way_o;
  logic mem_rev_v_i, mem_rev_ready_and_o;
  mem_msg_e mem_rev_type_i;
  paddr_t mem_rev_addr_i;
  block_t mem_rev_data_i;
  way_t mem_rev_way_i;

  // logs of everything the DUT sent out
  mem_msg_e fwd_type_q[$];
  paddr_t fwd_addr_q[$];
  logic [1:0] fwd_size_q[$];
  block_t fwd_data_q[$];
  way_t fwd_way_q[$];
  logic tag_clear_q[$];
  index_t tag_index_q[$];
  way_t tag_way_q[$];
  ctag_t tag_tag_q[$];
  block_t data_q[$];
  index_t data_index_q[$];
  way_t data_way_q[$];
  dword_t uc_q[$];
  int complete_cnt = 0;
  int ack_cnt = 0;

  // responder's outstanding commands, oldest first
  mem_msg_e pend_type_q[$];
  paddr_t pend_addr_q[$];
  way_t pend_way_q[$];
  int pend_due_q[$];
  logic rev_fired, hold_acks;

  int cycle = 0;
  int errors, test_errors, tests_run, tests_failed;
  integer seed;
  string test_name;

  uce_top u_uce_top (.*);

  initial
    begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
    end

  always @(posedge clk_i)
    begin
      cycle = cycle + 1;
      if (cycle >= timeout_cycles_lp)
        begin
          $display("Timeout: run did not finish within %0d cycles", timeout_cycles_lp);
          $display("Some tests failed");
          $finish;
        end
    end

  function automatic block_t model_block(paddr_t addr);
    block_t blk;
    for (int i = 0; i < `UCE_BLOCK_WIDTH / `UCE_DWORD_WIDTH; i++)
      blk[i*`UCE_DWORD_WIDTH +: `UCE_DWORD_WIDTH] = dword_t'(addr) ^ dword_t'(i);
    return blk;
  endfunction

  function automatic ctag_t tag_of(paddr_t addr);
    return ctag_t'(addr >> (`UCE_BLOCK_OFFSET_WIDTH + `UCE_INDEX_WIDTH));
  endfunction

  function automatic index_t index_of(paddr_t addr);
    return index_t'(addr >> `UCE_BLOCK_OFFSET_WIDTH);
  endfunction

  // memory and array model; samples at the falling edge, answers just after the rising edge
  initial
    begin
      mem_rev_v_i = 1'b0;
      mem_rev_type_i = e_mem_rd;
      mem_rev_addr_i = '0;
      mem_rev_data_i = '0;
      mem_rev_way_i = '0;
      rev_fired = 1'b0;
      forever
        begin
          @(negedge clk_i);
          if (!reset_i)
            begin
              if (mem_fwd_v_o && mem_fwd_ready_and_i)
                begin
                  fwd_type_q.push_back(mem_fwd_type_o);
                  fwd_addr_q.push_back(mem_fwd_addr_o);
                  fwd_size_q.push_back(mem_fwd_size_o);
                  fwd_data_q.push_back(mem_fwd_data_o);
                  fwd_way_q.push_back(mem_fwd_way_o);
                  pend_type_q.push_back(mem_fwd_type_o);
                  pend_addr_q.push_back(mem_fwd_addr_o);
                  pend_way_q.push_back(mem_fwd_way_o);
                  pend_due_q.push_back(cycle + resp_delay_lp);
                end
              if (tag_mem_v_o && tag_mem_yumi_i)
                begin
                  tag_clear_q.push_back(tag_mem_clear_o);
                  tag_index_q.push_back(tag_mem_index_o);
                  tag_way_q.push_back(tag_mem_way_o);
                  tag_tag_q.push_back(tag_mem_tag_o);
                end
              if (data_mem_v_o && data_mem_yumi_i)
                begin
                  data_q.push_back(data_mem_data_o);
                  data_index_q.push_back(data_mem_index_o);
                  data_way_q.push_back(data_mem_way_o);
                end
              if (uc_data_v_o && uc_data_yumi_i)
                uc_q.push_back(uc_data_o);
              if (cache_req_complete_o)
                complete_cnt++;
            end
          rev_fired = mem_rev_v_i && mem_rev_ready_and_o;
          @(posedge clk_i);
          #1;
          if (rev_fired)
            begin
              if (mem_rev_type_i == e_mem_uc_wr)
                ack_cnt++;
              pend_type_q.delete(0);
              pend_addr_q.delete(0);
              pend_way_q.delete(0);
              pend_due_q.delete(0);
              mem_rev_v_i = 1'b0;
            end
          if (!mem_rev_v_i && pend_type_q.size() > 0 && cycle >= pend_due_q[0]
              && !(hold_acks && pend_type_q[0] == e_mem_uc_wr))
            begin
              mem_rev_v_i = 1'b1;
              mem_rev_type_i = pend_type_q[0];
              mem_rev_addr_i = pend_addr_q[0];
              mem_rev_way_i = pend_way_q[0];
              // store acks carry no data
              mem_rev_data_i = (pend_type_q[0] == e_mem_uc_wr) ? '0 : model_block(pend_addr_q[0]);
            end
        end
    end

  task automatic start_test(string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0)
      $display("test %s: ok", test_name);
    else
      begin
        tests_failed++;
        $display("test %s: failed with %0d errors", test_name, test_errors);
      end
  endtask

  task automatic mismatch(string what, block_t expected, block_t actual);
    $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    test_errors++;
    errors++;
  endtask

  task automatic failure(string what);
    $display("Error in %s: %s", test_name, what);
    test_errors++;
    errors++;
  endtask

  task automatic send_req(req_type_e kind, paddr_t addr, logic [1:0] size, dword_t data,
                          way_t way);
    @(posedge clk_i);
    #1;
    cache_req_v_i = 1'b1;
    cache_req_type_i = kind;
    cache_req_addr_i = addr;
    cache_req_size_i = size;
    cache_req_data_i = data;
    cache_req_way_i = way;
    @(negedge clk_i);
    while (!cache_req_ready_and_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    cache_req_v_i = 1'b0;
  endtask

  task automatic test_init_clear();
    start_test("init_clear");
    while (cache_req_busy_o)
      @(negedge clk_i);
    @(posedge clk_i);
    if (tag_index_q.size() != `UCE_SETS)
      mismatch("clear count", block_t'(`UCE_SETS), block_t'(tag_index_q.size()));
    for (int i = 0; i < tag_index_q.size() && i < `UCE_SETS; i++)
      if (tag_index_q[i] !== index_t'(i) || tag_clear_q[i] !== 1'b1)
        mismatch("clear index", block_t'(i), block_t'(tag_index_q[i]));
    @(negedge clk_i);
    if (cache_req_busy_o !== 1'b0 || cache_req_ready_and_o !== 1'b1)
      failure("busy still high or ready low after init");
    end_test();
  endtask

  task automatic test_miss_fill();
    paddr_t addr, aligned;
    way_t way;
    int fwd0, tag0, data0, done0;
    start_test("miss_fill");
    addr = $random(seed);
    way = way_t'($random(seed));
    aligned = addr & ~paddr_t'(block_bytes_lp - 1);
    fwd0 = fwd_addr_q.size();
    tag0 = tag_tag_q.size();
    data0 = data_q.size();
    done0 = complete_cnt;
    send_req(e_miss_load, addr, 2'b11, '0, way);
    while (complete_cnt == done0)
      @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    if (fwd_addr_q.size() != fwd0 + 1 || tag_tag_q.size() != tag0 + 1
        || data_q.size() != data0 + 1)
      failure("expected one forward message, one tag write and one data write");
    else
      begin
        if (fwd_type_q[fwd0] !== e_mem_rd)
          mismatch("fwd type", block_t'(e_mem_rd), block_t'(fwd_type_q[fwd0]));
        if (fwd_addr_q[fwd0] !== aligned)
          mismatch("fwd addr", block_t'(aligned), block_t'(fwd_addr_q[fwd0]));
        if (fwd_way_q[fwd0] !== way)
          mismatch("fwd way", block_t'(way), block_t'(fwd_way_q[fwd0]));
        if (tag_tag_q[tag0] !== tag_of(addr))
          mismatch("tag", block_t'(tag_of(addr)), block_t'(tag_tag_q[tag0]));
        if (tag_index_q[tag0] !== index_of(addr))
          mismatch("tag index", block_t'(index_of(addr)), block_t'(tag_index_q[tag0]));
        if (tag_way_q[tag0] !== way)
          mismatch("tag way", block_t'(way), block_t'(tag_way_q[tag0]));
        if (data_q[data0] !== model_block(aligned))
          mismatch("fill data", model_block(aligned), data_q[data0]);
        if (data_index_q[data0] !== index_of(addr))
          mismatch("data index", block_t'(index_of(addr)), block_t'(data_index_q[data0]));
        if (data_way_q[data0] !== way)
          mismatch("data way", block_t'(way), block_t'(data_way_q[data0]));
      end
    if (complete_cnt != done0 + 1)
      mismatch("complete pulses", block_t'(1), block_t'(complete_cnt - done0));
    end_test();
  endtask

  task automatic test_uc_load();
    paddr_t addr;
    block_t blk;
    int fwd0, uc0, done0;
    start_test("uc_load");
    addr = $random(seed);
    blk = model_block(addr);
    fwd0 = fwd_addr_q.size();
    uc0 = uc_q.size();
    done0 = complete_cnt;
    send_req(e_uc_load, addr, 2'b10, '0, '0);
    while (complete_cnt == done0)
      @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    if (fwd_addr_q.size() != fwd0 + 1 || uc_q.size() != uc0 + 1)
      failure("expected one forward message and one uncached data return");
    else
      begin
        if (fwd_type_q[fwd0] !== e_mem_uc_rd)
          mismatch("fwd type", block_t'(e_mem_uc_rd), block_t'(fwd_type_q[fwd0]));
        if (fwd_addr_q[fwd0] !== addr)
          mismatch("fwd addr", block_t'(addr), block_t'(fwd_addr_q[fwd0]));
        if (fwd_size_q[fwd0] !== 2'b10)
          mismatch("fwd size", block_t'(2'b10), block_t'(fwd_size_q[fwd0]));
        if (uc_q[uc0] !== blk[`UCE_DWORD_WIDTH-1:0])
          mismatch("uc data", block_t'(blk[`UCE_DWORD_WIDTH-1:0]), block_t'(uc_q[uc0]));
      end
    if (complete_cnt != done0 + 1)
      mismatch("complete pulses", block_t'(1), block_t'(complete_cnt - done0));
    end_test();
  endtask

  task automatic test_uc_store();
    paddr_t addr;
    dword_t data;
    int fwd0, ack0, done0;
    start_test("uc_store");
    addr = $random(seed);
    data = {$random(seed), $random(seed)};
    fwd0 = fwd_addr_q.size();
    ack0 = ack_cnt;
    done0 = complete_cnt;
    @(negedge clk_i);
    hold_acks = 1'b1;
    send_req(e_uc_store, addr, 2'b11, data, '0);
    // second store goes in while the first is still unacknowledged
    send_req(e_uc_store, addr ^ 32'h40, 2'b10, ~data, '0);
    while (fwd_addr_q.size() < fwd0 + 2)
      @(posedge clk_i);
    if (fwd_addr_q[fwd0 + 1] !== (addr ^ 32'h40))
      mismatch("second store addr", block_t'(addr ^ 32'h40), block_t'(fwd_addr_q[fwd0 + 1]));
    if (fwd_type_q[fwd0] !== e_mem_uc_wr)
      mismatch("fwd type", block_t'(e_mem_uc_wr), block_t'(fwd_type_q[fwd0]));
    if (fwd_addr_q[fwd0] !== addr)
      mismatch("fwd addr", block_t'(addr), block_t'(fwd_addr_q[fwd0]));
    if (fwd_size_q[fwd0] !== 2'b11)
      mismatch("fwd size", block_t'(2'b11), block_t'(fwd_size_q[fwd0]));
    if (fwd_data_q[fwd0][`UCE_DWORD_WIDTH-1:0] !== data)
      mismatch("fwd data", block_t'(data), block_t'(fwd_data_q[fwd0][`UCE_DWORD_WIDTH-1:0]));
    @(negedge clk_i);
    hold_acks = 1'b0;
    while (ack_cnt < ack0 + 2)
      @(posedge clk_i);
    if (complete_cnt != done0)
      failure("complete pulsed for a store");
    end_test();
  endtask

  task automatic test_credit_limit();
    paddr_t base;
    int fwd0, ack0;
    start_test("credit_limit");
    base = $random(seed);
    fwd0 = fwd_addr_q.size();
    ack0 = ack_cnt;
    @(negedge clk_i);
    hold_acks = 1'b1;
    for (int i = 0; i < `UCE_MAX_CREDITS; i++)
      send_req(e_uc_store, paddr_t'(base + 8 * i), 2'b11, dword_t'(i), '0);
    while (fwd_addr_q.size() < fwd0 + `UCE_MAX_CREDITS)
      @(posedge clk_i);
    send_req(e_uc_store, paddr_t'(base + 8 * `UCE_MAX_CREDITS), 2'b11, '1, '0);
    repeat (5) @(posedge clk_i);
    if (fwd_addr_q.size() != fwd0 + `UCE_MAX_CREDITS)
      failure("store forwarded with no credit left");
    @(negedge clk_i);
    if (cache_req_credits_full_o !== 1'b1)
      failure("credits_full low with every credit in use and a store waiting");
    hold_acks = 1'b0;
    while (fwd_addr_q.size() < fwd0 + `UCE_MAX_CREDITS + 1)
      @(posedge clk_i);
    if (fwd_addr_q[fwd0 + `UCE_MAX_CREDITS] !== paddr_t'(base + 8 * `UCE_MAX_CREDITS))
      mismatch("late store addr", block_t'(paddr_t'(base + 8 * `UCE_MAX_CREDITS)),
               block_t'(fwd_addr_q[fwd0 + `UCE_MAX_CREDITS]));
    while (ack_cnt < ack0 + `UCE_MAX_CREDITS + 1)
      @(posedge clk_i);
    @(negedge clk_i);
    if (cache_req_credits_empty_o !== 1'b1)
      failure("credits_empty low after every store was acknowledged");
    end_test();
  endtask

  initial
    begin
      seed = 32'h83b7a3b2;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      hold_acks = 1'b0;
      reset_i = 1'b1;
      cache_req_v_i = 1'b0;
      cache_req_type_i = e_miss_load;
      cache_req_addr_i = '0;
      cache_req_size_i = '0;
      cache_req_data_i = '0;
      cache_req_way_i = '0;
      tag_mem_yumi_i = 1'b1;
      data_mem_yumi_i = 1'b1;
      uc_data_yumi_i = 1'b1;
      mem_fwd_ready_and_i = 1'b1;
      repeat (3) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      test_init_clear();
      test_miss_fill();
      test_uc_load();
      test_uc_store();
      test_credit_limit();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
        $display("All tests passed");
      else
        $display("Some tests failed");
      $finish;
    end

endmodule

//--- sim.f
+incdir+.
uce_pkg.sv
uce_req_reg.sv
uce_credit_counter.sv
uce_fsm.sv
uce_top.sv
tb_uce.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the UCE testbench with Verilator; exits non-zero on any failure
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_uce -f sim.f -o tb_uce_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_uce_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0
